// File: rv_core_top.f
hw/rv_pkg.sv
hw/rv_decode.sv
hw/rv_operand_fwd.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core_top.sv
tests/rv_core_tb.sv

// File: tests/rv_testdata.txt
// columns (hex): instruction, pc, expected illegal, rd, wreg, data
// records retire in this order; registers start at zero after reset
007302b3 00001000 0 05 1 00000000 // add   x5, x6, x7
123450b7 00001004 0 01 1 12345000 // lui   x1, 0x12345
67808093 00001008 0 01 1 12345678 // addi  x1, x1, 0x678
fff00113 0000100c 0 02 1 ffffffff // addi  x2, x0, -1
00500193 00001010 0 03 1 00000005 // addi  x3, x0, 5
00312233 00001014 0 04 1 00000001 // slt   x4, x2, x3
00313233 00001018 0 04 1 00000000 // sltu  x4, x2, x3
00012313 0000101c 0 06 1 00000001 // slti  x6, x2, 0
fff1b393 00001020 0 07 1 00000001 // sltiu x7, x3, -1
80000437 00001024 0 08 1 80000000 // lui   x8, 0x80000
40445493 00001028 0 09 1 f8000000 // srai  x9, x8, 4
00445513 0000102c 0 0a 1 08000000 // srli  x10, x8, 4
403455b3 00001030 0 0b 1 fc000000 // sra   x11, x8, x3
00345633 00001034 0 0c 1 04000000 // srl   x12, x8, x3
00319693 00001038 0 0d 1 00000028 // slli  x13, x3, 3
00d19733 0000103c 0 0e 1 00000500 // sll   x14, x3, x13
401187b3 00001040 0 0f 1 edcba98d // sub   x15, x3, x1
0020c833 00001044 0 10 1 edcba987 // xor   x16, x1, x2
00d868b3 00001048 0 11 1 edcba9af // or    x17, x16, x13
0018f933 0000104c 0 12 1 00000028 // and   x18, x17, x1
fff0c993 00001050 0 13 1 edcba987 // xori  x19, x1, -1
7f01ea13 00001054 0 14 1 000007f5 // ori   x20, x3, 0x7f0
0f017a93 00001058 0 15 1 000000f0 // andi  x21, x2, 0xf0
00001b17 0000105c 0 16 1 0000205c // auipc x22, 0x1
fffffb97 00001060 0 17 1 00000060 // auipc x23, 0xfffff
00718013 00001064 0 00 1 0000000c // addi  x0, x3, 7
00000c33 00001068 0 18 1 00000000 // add   x24, x0, x0
abcde037 0000106c 0 00 1 abcde000 // lui   x0, 0xabcde
00306cb3 00001070 0 19 1 00000005 // or    x25, x0, x3
0000ad03 00001074 1 1a 0 00000000 // lw    x26, 0(x1)
003d0db3 00001078 0 1b 1 00000005 // add   x27, x26, x3
00208463 0000107c 1 08 0 00000000 // beq   x1, x2, +8
00040e33 00001080 0 1c 1 80000000 // add   x28, x8, x0
4010ceb3 00001084 1 1d 0 00000000 // xor with funct7 0x20
001e0f13 00001088 0 1e 1 80000001 // addi  x30, x28, 1
41cf0fb3 0000108c 0 1f 1 00000001 // sub   x31, x30, x28
01df82b3 00001090 0 05 1 00000001 // add   x5, x31, x29
0095a333 00001094 0 06 1 00000000 // slt   x6, x11, x9
002433b3 00001098 0 07 1 00000001 // sltu  x7, x8, x2
00728533 0000109c 0 0a 1 00000002 // add   x10, x5, x7

// File: tests/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    localparam int MAX_RECS   = 64;
    localparam int REC_WORDS  = 6;    // inst, pc, illegal, rd, wreg, data
    localparam int WAIT_LIMIT = 20;

    logic                      clk;
    logic                      rst_n;
    logic                      inst_valid;
    logic [rv_pkg::XLEN-1:0]   inst;
    logic [rv_pkg::XLEN-1:0]   pc;
    rv_pkg::ex_wb_t            retire;

    logic [31:0]               tdata [MAX_RECS*REC_WORDS];
    rv_pkg::ex_wb_t            exp_q [$];   // in-order expected retires
    int                        n_recs         = 0;
    int                        pending_cycles = 0;

    rv_core_top DUT (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .pc_i         (pc),
        .retire_o     (retire)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        abort_run();
    endtask

    task automatic check_retire(input rv_pkg::ex_wb_t got, input rv_pkg::ex_wb_t exp);
        if (got.illegal !== exp.illegal) begin
            report_mismatch("DUT.retire_o.illegal", got.illegal, exp.illegal);
        end else if (got.rd !== exp.rd) begin
            report_mismatch("DUT.retire_o.rd", got.rd, exp.rd);
        end else if (got.wreg !== exp.wreg) begin
            report_mismatch("DUT.retire_o.wreg", got.wreg, exp.wreg);
        end else if (got.data !== exp.data) begin
            report_mismatch("DUT.retire_o.data", got.data, exp.data);
        end
    endtask

    task automatic check_idle(input rv_pkg::ex_wb_t got);
        if (got.valid !== 1'b0) begin
            report_mismatch("DUT.retire_o.valid", got.valid, 1'b0);
        end
    endtask

    task automatic load_testdata();
        for (int k = 0; k < MAX_RECS*REC_WORDS; k++) begin
            tdata[k] = 32'hbad0_0000 | k;   // marks words the file leaves unset
        end
        $readmemh("tests/rv_testdata.txt", tdata);
        // the illegal column is 0 or 1 in every real record
        while ((n_recs < MAX_RECS) && (tdata[n_recs*REC_WORDS+2] <= 32'd1)) begin
            n_recs++;
        end
        if (n_recs == 0) begin
            $display("No instruction records were read from tests/rv_testdata.txt");
            abort_run();
        end
    endtask

    task automatic drive_inst(input int idx);
        rv_pkg::ex_wb_t exp;
        int             base;
        base        = idx * REC_WORDS;
        exp.valid   = 1'b1;
        exp.illegal = tdata[base+2][0];
        exp.rd      = tdata[base+3][rv_pkg::REG_AW-1:0];
        exp.wreg    = tdata[base+4][0];
        exp.data    = tdata[base+5];
        @(posedge clk);
        inst_valid <= 1'b1;
        inst       <= tdata[base];
        pc         <= tdata[base+1];
        exp_q.push_back(exp);
    endtask

    task automatic drive_idle();
        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= $urandom;   // garbage on a bubble must never write
        pc         <= $urandom;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout: %0d instructions did not retire within %0d cycles",
                         exp_q.size(), WAIT_LIMIT);
                abort_run();
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
    endtask

    // retire monitor samples mid-cycle while retire is stable
    initial begin
        forever begin
            @(negedge clk);
            if (!rst_n) begin
                check_idle(retire);
            end else if (retire.valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Retire seen at %0t with no instruction in flight", $time);
                    abort_run();
                end else begin
                    check_retire(retire, exp_q.pop_front());
                    pending_cycles = 0;
                end
            end else if (exp_q.size() == 0) begin
                check_idle(retire);
                pending_cycles = 0;
            end else begin
                pending_cycles++;   // oldest instruction still in flight
                if (pending_cycles > WAIT_LIMIT) begin
                    $display("Timeout: no retire within %0d cycles at %0t",
                             WAIT_LIMIT, $time);
                    abort_run();
                end
            end
        end
    end

    initial begin
        int gap;
        void'($urandom(32'hdd6));
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        load_testdata();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) drive_idle();   // retire stays quiet before the first instruction
        for (int i = 0; i < n_recs; i++) begin
            drive_inst(i);
            gap = $urandom % 3;
            repeat (gap) drive_idle();
        end
        drive_idle();
        wait_drain();
        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: hw/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    inst_valid_i,
    input  logic [rv_pkg::XLEN-1:0] inst_i,
    input  logic [rv_pkg::XLEN-1:0] pc_i,
    output rv_pkg::ex_wb_t          retire_o
);

    rv_pkg::dec_ctrl_t          ctrl;
    rv_pkg::id_ex_t             id_ex;
    rv_pkg::ex_wb_t             ex_result;
    rv_pkg::fwd_src_t           ex_fwd;
    rv_pkg::fwd_src_t           wb_fwd;     // also the regfile write
    logic [rv_pkg::REG_AW-1:0]  rs1_addr;
    logic [rv_pkg::REG_AW-1:0]  rs2_addr;
    logic [rv_pkg::XLEN-1:0]    rs1_data;
    logic [rv_pkg::XLEN-1:0]    rs2_data;

    rv_decode u_decode (
        .inst_i     (inst_i),
        .pc_i       (pc_i),
        .ctrl_o     (ctrl)
    );

    rv_operand_fwd u_operand_fwd (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (inst_valid_i),
        .ctrl_i     (ctrl),
        .pc_i       (pc_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .ex_fwd_i   (ex_fwd),
        .wb_fwd_i   (wb_fwd),
        .id_ex_o    (id_ex)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_i       (wb_fwd)
    );

    rv_execute u_execute (
        .id_ex_i    (id_ex),
        .ex_fwd_o   (ex_fwd),
        .result_o   (ex_result)
    );

    rv_result u_result (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .result_i   (ex_result),
        .wb_fwd_o   (wb_fwd),
        .retire_o   (retire_o)
    );

endmodule

// File: hw/rv_result.sv
`timescale 1ns/10ps

module rv_result (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  rv_pkg::ex_wb_t      result_i,
    output rv_pkg::fwd_src_t    wb_fwd_o,
    output rv_pkg::ex_wb_t      retire_o
);

    rv_pkg::ex_wb_t retire_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_q <= '0;
        end else begin
            retire_q <= result_i;
        end
    end

    // one record feeds retire, regfile write and forwarding
    assign retire_o = retire_q;

    always_comb begin
        wb_fwd_o.wreg = retire_q.valid && retire_q.wreg;
        wb_fwd_o.rd   = retire_q.rd;
        wb_fwd_o.data = retire_q.data;
    end

    a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        retire_q.illegal && retire_q.valid |-> !wb_fwd_o.wreg);

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
    input  rv_pkg::id_ex_t      id_ex_i,
    output rv_pkg::fwd_src_t    ex_fwd_o,
    output rv_pkg::ex_wb_t      result_o
);

    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [4:0]              shamt;
    logic                    wr_en;

    assign shamt = id_ex_i.opb[4:0];   // low 5 bits only
    assign wr_en = id_ex_i.valid && id_ex_i.wreg;

    always_comb begin
        case (id_ex_i.op)
            rv_pkg::ALU_ADD:  alu_res = id_ex_i.opa + id_ex_i.opb;
            rv_pkg::ALU_SUB:  alu_res = id_ex_i.opa - id_ex_i.opb;
            rv_pkg::ALU_SLL:  alu_res = id_ex_i.opa << shamt;
            rv_pkg::ALU_SLT: begin
                alu_res = {31'b0, $signed(id_ex_i.opa) < $signed(id_ex_i.opb)};
            end
            rv_pkg::ALU_SLTU: alu_res = {31'b0, id_ex_i.opa < id_ex_i.opb};
            rv_pkg::ALU_XOR:  alu_res = id_ex_i.opa ^ id_ex_i.opb;
            rv_pkg::ALU_SRL:  alu_res = id_ex_i.opa >> shamt;
            rv_pkg::ALU_SRA:  alu_res = $unsigned($signed(id_ex_i.opa) >>> shamt);
            rv_pkg::ALU_OR:   alu_res = id_ex_i.opa | id_ex_i.opb;
            rv_pkg::ALU_AND:  alu_res = id_ex_i.opa & id_ex_i.opb;
            rv_pkg::ALU_LUI:  alu_res = id_ex_i.opb;   // imm already shifted
            rv_pkg::ALU_NONE: alu_res = '0;            // illegal retires zero
            default:          alu_res = '0;
        endcase
    end

    // forwarding source back to the operand mux
    always_comb begin
        ex_fwd_o.wreg = wr_en;
        ex_fwd_o.rd   = id_ex_i.rd;
        ex_fwd_o.data = alu_res;
    end

    always_comb begin
        result_o.valid   = id_ex_i.valid;
        result_o.rd      = id_ex_i.rd;
        result_o.wreg    = wr_en;
        result_o.illegal = id_ex_i.illegal;
        result_o.data    = alu_res;
    end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [rv_pkg::REG_AW-1:0]   rs1_addr_i,
    input  logic [rv_pkg::REG_AW-1:0]   rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]     rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]     rs2_data_o,
    input  rv_pkg::fwd_src_t            wr_i
);

    logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_i.wreg && (wr_i.rd != '0)) begin   // x0 writes dropped
            regs[wr_i.rd] <= wr_i.data;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];   // async read
    assign rs2_data_o = regs[rs2_addr_i];

endmodule

// File: hw/rv_operand_fwd.sv
`timescale 1ns/10ps

module rv_operand_fwd (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  rv_pkg::dec_ctrl_t           ctrl_i,
    input  logic [rv_pkg::XLEN-1:0]     pc_i,
    output logic [rv_pkg::REG_AW-1:0]   rs1_addr_o,
    output logic [rv_pkg::REG_AW-1:0]   rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]     rs2_data_i,
    input  rv_pkg::fwd_src_t            ex_fwd_i,
    input  rv_pkg::fwd_src_t            wb_fwd_i,
    output rv_pkg::id_ex_t              id_ex_o
);

    logic [rv_pkg::XLEN-1:0] opa;
    logic [rv_pkg::XLEN-1:0] opb;

    // x0, then execute, then result stage, then register file
    function automatic logic [rv_pkg::XLEN-1:0] pick_operand(
        input logic                      use_reg,
        input logic [rv_pkg::REG_AW-1:0] addr,
        input logic [rv_pkg::XLEN-1:0]   rf_data,
        input logic [rv_pkg::XLEN-1:0]   other,
        input rv_pkg::fwd_src_t          ex_fwd,
        input rv_pkg::fwd_src_t          wb_fwd
    );
        if (!use_reg) begin
            return other;
        end else if (addr == '0) begin
            return '0;
        end else if (ex_fwd.wreg && (ex_fwd.rd == addr)) begin
            return ex_fwd.data;
        end else if (wb_fwd.wreg && (wb_fwd.rd == addr)) begin
            return wb_fwd.data;
        end
        return rf_data;
    endfunction

    assign rs1_addr_o = ctrl_i.rs1;
    assign rs2_addr_o = ctrl_i.rs2;

    assign opa = pick_operand(ctrl_i.use_rs1, ctrl_i.rs1, rs1_data_i,
                              ctrl_i.use_pc ? pc_i : '0, ex_fwd_i, wb_fwd_i);
    assign opb = pick_operand(ctrl_i.use_rs2, ctrl_i.rs2, rs2_data_i,
                              ctrl_i.imm, ex_fwd_i, wb_fwd_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_o <= '0;
        end else begin
            id_ex_o.valid   <= valid_i;
            id_ex_o.op      <= ctrl_i.op;
            id_ex_o.opa     <= opa;
            id_ex_o.opb     <= opb;
            id_ex_o.rd      <= ctrl_i.rd;
            id_ex_o.wreg    <= ctrl_i.wreg && valid_i;   // bubbles never write
            id_ex_o.illegal <= ctrl_i.illegal;
        end
    end

    a_valid_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(id_ex_o.valid));

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::inst_fmt_u         inst_i,
    input  logic [rv_pkg::XLEN-1:0]   pc_i,
    output rv_pkg::dec_ctrl_t         ctrl_o
);

    rv_pkg::alu_op_e op;
    logic            legal;
    logic            f7_alt;    // funct7 is zero apart from the alt bit
    logic            f7_zero;   // funct7 all zero
    logic            is_shift_imm;
    logic [6:0]      opcode;
    logic [2:0]      funct3;

    assign opcode  = inst_i.r.opcode;
    assign funct3  = inst_i.r.funct3;
    assign f7_alt  = ({inst_i.r.funct7[6], inst_i.r.funct7[4:0]} == 6'b0);
    assign f7_zero = f7_alt && !inst_i[rv_pkg::ALT_BIT];
    assign is_shift_imm = (funct3 == rv_pkg::F3_SLL) || (funct3 == rv_pkg::F3_SR);

    always_comb begin
        op = rv_pkg::ALU_NONE;
        case (opcode)
            rv_pkg::OPC_LUI:   op = rv_pkg::ALU_LUI;
            rv_pkg::OPC_AUIPC: op = rv_pkg::ALU_ADD;   // pc + upper imm
            rv_pkg::OPC_OP_IMM: begin
                case (funct3)
                    rv_pkg::F3_ADD:  op = rv_pkg::ALU_ADD;
                    rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
                    rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
                    rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
                    rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
                    rv_pkg::F3_AND:  op = rv_pkg::ALU_AND;
                    rv_pkg::F3_SLL: begin
                        if (f7_zero) begin
                            op = rv_pkg::ALU_SLL;
                        end
                    end
                    rv_pkg::F3_SR: begin
                        if (f7_alt) begin
                            op = inst_i[rv_pkg::ALT_BIT] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                        end
                    end
                    default: op = rv_pkg::ALU_NONE;
                endcase
            end
            rv_pkg::OPC_OP: begin
                if (f7_zero) begin
                    case (funct3)
                        rv_pkg::F3_ADD:  op = rv_pkg::ALU_ADD;
                        rv_pkg::F3_SLL:  op = rv_pkg::ALU_SLL;
                        rv_pkg::F3_SLT:  op = rv_pkg::ALU_SLT;
                        rv_pkg::F3_SLTU: op = rv_pkg::ALU_SLTU;
                        rv_pkg::F3_XOR:  op = rv_pkg::ALU_XOR;
                        rv_pkg::F3_SR:   op = rv_pkg::ALU_SRL;
                        rv_pkg::F3_OR:   op = rv_pkg::ALU_OR;
                        rv_pkg::F3_AND:  op = rv_pkg::ALU_AND;
                        default:         op = rv_pkg::ALU_NONE;
                    endcase
                end else if (f7_alt) begin
                    // only add and srl have an alternate form
                    if (funct3 == rv_pkg::F3_ADD) begin
                        op = rv_pkg::ALU_SUB;
                    end else if (funct3 == rv_pkg::F3_SR) begin
                        op = rv_pkg::ALU_SRA;
                    end
                end
            end
            default: op = rv_pkg::ALU_NONE;
        endcase
    end

    assign legal = (op != rv_pkg::ALU_NONE);

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.op      = op;
        ctrl_o.use_rs1 = legal && ((opcode == rv_pkg::OPC_OP_IMM) || (opcode == rv_pkg::OPC_OP));
        ctrl_o.use_rs2 = legal && (opcode == rv_pkg::OPC_OP);
        ctrl_o.rs1     = inst_i.r.rs1;
        ctrl_o.rs2     = inst_i.r.rs2;
        ctrl_o.rd      = inst_i.r.rd;
        ctrl_o.wreg    = legal;
        ctrl_o.illegal = !legal;
        ctrl_o.use_pc  = legal && (opcode == rv_pkg::OPC_AUIPC);
        if ((opcode == rv_pkg::OPC_LUI) || (opcode == rv_pkg::OPC_AUIPC)) begin
            ctrl_o.imm = {inst_i.u.imm20, 12'b0};
        end else if ((opcode == rv_pkg::OPC_OP_IMM) && is_shift_imm) begin
            ctrl_o.imm = {27'b0, inst_i.i.imm12[4:0]};   // shamt
        end else if (opcode == rv_pkg::OPC_OP_IMM) begin
            ctrl_o.imm = {{20{inst_i.i.imm12[11]}}, inst_i.i.imm12};
        end
    end

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

    localparam int XLEN     = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // major opcodes kept by this core
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    localparam logic [2:0] F3_ADD  = 3'b000;   // add, sub, addi
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;   // srl, sra and immediates
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam int ALT_BIT = 30;               // sub / sra select

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_LUI
    } alu_op_e;

    // one instruction word in three field layouts
    typedef union packed {
        struct packed {
            logic [6:0]        funct7;
            logic [REG_AW-1:0] rs2;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } r;
        struct packed {
            logic [11:0]       imm12;
            logic [REG_AW-1:0] rs1;
            logic [2:0]        funct3;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } i;
        struct packed {
            logic [19:0]       imm20;
            logic [REG_AW-1:0] rd;
            logic [6:0]        opcode;
        } u;
    } inst_fmt_u;

    typedef struct packed {
        alu_op_e           op;
        logic              use_rs1;
        logic              use_rs2;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic              wreg;
        logic              illegal;
        logic [XLEN-1:0]   imm;
        logic              use_pc;   // operand a is the pc (auipc)
    } dec_ctrl_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [XLEN-1:0]   opa;
        logic [XLEN-1:0]   opb;
        logic [REG_AW-1:0] rd;
        logic              wreg;
        logic              illegal;
    } id_ex_t;

    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic              wreg;
        logic              illegal;
        logic [XLEN-1:0]   data;
    } ex_wb_t;

    typedef struct packed {
        logic              wreg;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } fwd_src_t;

endpackage
